// File: sim.f
regmap_pkg.sv
capture_pkg.sv
wb_reg_decode.sv
capture_config.sv
sensor_select.sv
capture_fsm.sv
sample_ram.sv
data_buffer_top.sv
data_buffer_assert.sv
tb_data_buffer.sv

// File: Makefile
# Verilator build and run for the data collection buffer testbench
VERILATOR ?= verilator
TOP       ?= tb_data_buffer
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing
LINTFLAGS ?= --lint-only -Wall --assert --timing

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "STATUS: PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_data_buffer.sv
// testbench for the data collection buffer
// configures frame layouts over wishbone, sends sample strobes with
// pseudo-random sensor readings, checks RAM words and the status register
`timescale 1ns/1ps
`default_nettype none

module tb_data_buffer;

    localparam int BUS_TIMEOUT = 16;    // cycles to wait for ack
    localparam int POLL_LIMIT  = 64;    // status reads before giving up

    logic                                 clkbuffer;
    logic                                 rst_n;
    regmap_pkg::wb_req_t                  wb_req;
    regmap_pkg::wb_rsp_t                  wb_rsp;
    logic                                 sample_strobe;
    logic [31:0]                          ts;
    logic [capture_pkg::NUM_CH-1:0][15:0] pot_values;
    logic [capture_pkg::NUM_CH-1:0][15:0] cur_values;
    logic [capture_pkg::NUM_CH-1:0][31:0] enc_values;

    // host-side copy of the frame layout
    logic [3:0]  spec_src [capture_pkg::MAX_SIGNALS];
    logic [3:0]  spec_ch  [capture_pkg::MAX_SIGNALS];
    logic [3:0]  spec_fmt [capture_pkg::MAX_SIGNALS];
    int          num_sig;
    logic [31:0] expected [capture_pkg::RAM_DEPTH];   // model of RAM contents
    logic [15:0] lfsr_state = 16'd52;
    logic [31:0] rdat;
    logic [11:0] holes [4] = '{12'h400, 12'h7ff, 12'h906, 12'hfff};   // unmapped

    data_buffer_top data_buffer_top_inst (
        .clkbuffer     (clkbuffer),
        .rst_n         (rst_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .sample_strobe (sample_strobe),
        .ts            (ts),
        .pot_values    (pot_values),
        .cur_values    (cur_values),
        .enc_values    (enc_values)
    );

    initial begin
        clkbuffer = 1'b0;
        forever #5 clkbuffer = ~clkbuffer;
    end

    // helpers --------------------
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return r;
    endfunction

    // one classic cycle, request held through the ack cycle
    task automatic bus_access(input logic we, input logic [11:0] adr,
                              input logic [31:0] dat, output logic [31:0] rd);
        int n;
        n = 0;
        @(negedge clkbuffer);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge clkbuffer);
            n++;
        end while (!wb_rsp.ack && n < BUS_TIMEOUT);
        if (wb_rsp.ack) begin
            rd = wb_rsp.dat;
            @(negedge clkbuffer);
            wb_req = '{default: '0};
        end else begin
            $display("bus access to address %h got no ack", adr);
            abort_run();
        end
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] dat);
        logic [31:0] unused_rd;
        bus_access(1'b1, adr, dat, unused_rd);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] rd);
        bus_access(1'b0, adr, 32'd0, rd);
    endtask

    task automatic set_layout(input int n);
        bus_write(regmap_pkg::REG_NUM, n);
        num_sig = 0;
    endtask

    task automatic add_spec(input logic [3:0] src, input logic [3:0] ch, input logic [3:0] fmt);
        bus_write(regmap_pkg::REG_SPEC, {16'd0, src, 4'd0, ch, fmt});
        spec_src[num_sig] = src;
        spec_ch[num_sig]  = ch;
        spec_fmt[num_sig] = fmt;
        num_sig++;
    endtask

    // reading for spec i, zero for missing channels and unknown sources
    function automatic logic [31:0] expect_reading(input int i);
        logic [31:0] raw;
        int          width;
        raw = 32'd0;
        if (spec_ch[i] < 4'd4) begin
            if (spec_src[i] == capture_pkg::src_pot) raw = {16'd0, pot_values[spec_ch[i][1:0]]};
            if (spec_src[i] == capture_pkg::src_cur) raw = {16'd0, cur_values[spec_ch[i][1:0]]};
            if (spec_src[i] == capture_pkg::src_enc) raw = enc_values[spec_ch[i][1:0]];
        end
        width = (spec_fmt[i] == 4'd0) ? 8 : (spec_fmt[i] == 4'd1) ? 16 :
                (spec_fmt[i] == 4'd2) ? 24 : 32;
        if (width < 32) raw = raw & ((32'd1 << width) - 32'd1);
        return raw;
    endfunction

    // new readings and timestamp, expected words from base, then one strobe
    task automatic capture_frame(input logic [31:0] ts_val, input int base);
        @(negedge clkbuffer);
        ts = ts_val;
        for (int c = 0; c < capture_pkg::NUM_CH; c++) begin
            pot_values[c] = 16'(rand_bits(16));
            cur_values[c] = 16'(rand_bits(16));
            enc_values[c] = rand_bits(32);
        end
        expected[base % capture_pkg::RAM_DEPTH] =
            {16'd0, 1'b1, (ts_val >= 32'd16384), ts_val[13:0]};
        for (int i = 0; i < num_sig; i++) begin
            expected[(base + 1 + i) % capture_pkg::RAM_DEPTH] = expect_reading(i);
        end
        sample_strobe = 1'b1;
        repeat (2) @(negedge clkbuffer);
        sample_strobe = 1'b0;
    endtask

    task automatic wait_align(input logic [9:0] exp);
        logic [31:0] s;
        int          n;
        n = 0;
        do begin
            bus_read(regmap_pkg::REG_STATUS, s);
            n++;
        end while (s[9:0] != exp && n < POLL_LIMIT);
        if (s[9:0] != exp) begin
            $display("frame did not complete, write address stuck at %0d", s[9:0]);
            abort_run();
        end
    endtask

    task automatic wait_idle();
        logic [31:0] s;
        int          n;
        n = 0;
        do begin
            bus_read(regmap_pkg::REG_STATUS, s);
            n++;
        end while (s[15] && n < POLL_LIMIT);
        if (s[15]) begin
            $display("collection never went idle");
            abort_run();
        end
    endtask

    task automatic check_status(input logic busy, input logic [3:0] num, input logic [9:0] align);
        logic [31:0] s;
        bus_read(regmap_pkg::REG_STATUS, s);
        check_eq("status.busy", {31'd0, s[15]}, {31'd0, busy});
        check_eq("status.num", {28'd0, s[13:10]}, {28'd0, num});
        check_eq("status.waddr_align", {22'd0, s[9:0]}, {22'd0, align});
    endtask

    task automatic check_ram(input int first, input int count);
        logic [31:0] w;
        for (int a = first; a < first + count; a++) begin
            bus_read(12'(a), w);
            check_eq($sformatf("ram[%0d]", a), w, expected[a]);
        end
    endtask

    // test sequence --------------------
    initial begin
        rst_n         = 1'b0;
        wb_req        = '{default: '0};
        sample_strobe = 1'b0;
        ts            = '0;
        pot_values    = '0;
        cur_values    = '0;
        enc_values    = '0;
        num_sig       = 0;
        repeat (2) @(posedge clkbuffer);
        @(negedge clkbuffer);
        rst_n = 1'b1;

        // reset state, ack quiet with no request
        bus_read(regmap_pkg::REG_STATUS, rdat);
        check_eq("status after reset", rdat, 32'd0);
        repeat (4) begin
            @(negedge clkbuffer);
            check_eq("wb_rsp.ack while idle", {31'd0, wb_rsp.ack}, 32'd0);
        end

        // sample mode, two frames of three signals
        set_layout(3);
        add_spec(capture_pkg::src_pot, 4'd1, capture_pkg::fmt_16);
        add_spec(capture_pkg::src_cur, 4'd3, capture_pkg::fmt_8);
        add_spec(capture_pkg::src_enc, 4'd0, capture_pkg::fmt_32);
        bus_write(regmap_pkg::REG_MODE_SAMPLE, 32'd2);
        bus_write(regmap_pkg::REG_START, 32'd0);
        capture_frame(rand_bits(14), 0);              // ts fits in 14 bits
        wait_align(10'd4);
        capture_frame(32'h0003_0000 + rand_bits(16), 4);   // over-14 flag set
        wait_idle();
        check_status(1'b0, 4'd3, 10'd8);
        check_ram(0, 8);

        // continuous mode, three frames then stop
        bus_write(regmap_pkg::REG_MODE_CONT, 32'd0);
        bus_write(regmap_pkg::REG_START, 32'd0);
        for (int f = 0; f < 3; f++) begin
            capture_frame(rand_bits(32), f * (1 + num_sig));
            wait_align(10'((f + 1) * (1 + num_sig)));
        end
        bus_write(regmap_pkg::REG_STOP, 32'd0);
        wait_idle();
        check_status(1'b0, 4'd3, 10'd12);
        check_ram(8, 4);

        // count write while busy is dropped
        bus_write(regmap_pkg::REG_START, 32'd0);
        check_status(1'b1, 4'd3, 10'd0);
        bus_write(regmap_pkg::REG_NUM, 32'd5);
        check_status(1'b1, 4'd3, 10'd0);
        bus_write(regmap_pkg::REG_STOP, 32'd0);
        wait_idle();

        // incomplete layout, start has no effect
        set_layout(2);
        add_spec(capture_pkg::src_pot, 4'd0, capture_pkg::fmt_16);
        bus_write(regmap_pkg::REG_START, 32'd0);
        check_status(1'b0, 4'd2, 10'd0);

        // unknown source and channel 5 store zero
        set_layout(2);
        add_spec(4'd7, 4'd0, capture_pkg::fmt_32);
        add_spec(capture_pkg::src_pot, 4'd5, capture_pkg::fmt_32);
        bus_write(regmap_pkg::REG_MODE_SAMPLE, 32'd1);
        bus_write(regmap_pkg::REG_START, 32'd0);
        capture_frame(rand_bits(32), 0);
        wait_idle();
        check_status(1'b0, 4'd2, 10'd3);
        check_ram(0, 1);
        bus_read(12'd1, rdat);
        check_eq("ram[1] unknown source", rdat, 32'd0);
        bus_read(12'd2, rdat);
        check_eq("ram[2] channel 5", rdat, 32'd0);

        // unmapped reads and the last RAM read address
        for (int h = 0; h < 4; h++) begin
            bus_read(holes[h], rdat);
            check_eq($sformatf("read of %h", holes[h]), rdat, 32'd0);
        end
        bus_read(12'h2a7, rdat);
        bus_read(regmap_pkg::REG_STATUS, rdat);
        check_eq("status last RAM read", {22'd0, rdat[25:16]}, 32'h0000_02a7);

        if (data_buffer_top_inst.data_buffer_assert_inst.fail_seen) begin
            $display("a bound bus or RAM write assertion failed during the run");
            abort_run();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: data_buffer_assert.sv
// bound checks for the data collection buffer
// wishbone handshake shape and capture RAM write rules
`timescale 1ns/1ps
`default_nettype none

module data_buffer_assert (
    input  logic                        clkbuffer,
    input  logic                        rst_n,
    input  regmap_pkg::wb_req_t         wb_req,
    input  regmap_pkg::wb_rsp_t         wb_rsp,
    input  capture_pkg::ram_wr_t        ram_wr,
    input  capture_pkg::buf_status_t    status
);

    logic busy_q;
    logic first_pend;             // started and no RAM write yet
    bit   ack_orphan  = 1'b0;
    bit   ack_twice   = 1'b0;
    bit   wr_idle     = 1'b0;
    bit   first_addr  = 1'b0;
    logic fail_seen;              // any property has fired

    // start tracking --------------------
    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            first_pend <= 1'b0;
        end else begin
            busy_q <= status.busy;
            if (status.busy && !busy_q) begin
                first_pend <= 1'b1;       // busy just rose
            end else if (ram_wr.en) begin
                first_pend <= 1'b0;
            end
        end
    end

    ack_needs_req: assert property (@(posedge clkbuffer) disable iff (!rst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            $error("ack without cyc and stb");
            ack_orphan = 1'b1;
        end

    ack_single: assert property (@(posedge clkbuffer) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("ack high two cycles in a row");
            ack_twice = 1'b1;
        end

    write_only_busy: assert property (@(posedge clkbuffer) disable iff (!rst_n)
        ram_wr.en |-> status.busy)
        else begin
            $error("RAM write while not busy");
            wr_idle = 1'b1;
        end

    first_write_zero: assert property (@(posedge clkbuffer) disable iff (!rst_n)
        (ram_wr.en && first_pend) |-> (ram_wr.addr == '0))
        else begin
            $error("first write after start not at address 0");
            first_addr = 1'b1;
        end

    assign fail_seen = ack_orphan || ack_twice || wr_idle || first_addr;

endmodule

bind data_buffer_top data_buffer_assert data_buffer_assert_inst (
    .clkbuffer (clkbuffer),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .ram_wr    (ram_wr),
    .status    (status)
);

`default_nettype wire

// File: data_buffer_top.sv
// data collection buffer top level
// host bus decode, layout config, sensor select, capture FSM and sample RAM
`timescale 1ns/1ps
`default_nettype none

module data_buffer_top (
    input  logic                                clkbuffer,
    input  logic                                rst_n,
    input  regmap_pkg::wb_req_t                 wb_req,
    output regmap_pkg::wb_rsp_t                 wb_rsp,
    input  logic                                sample_strobe,
    input  logic [31:0]                         ts,
    input  logic [capture_pkg::NUM_CH-1:0][15:0] pot_values,
    input  logic [capture_pkg::NUM_CH-1:0][15:0] cur_values,
    input  logic [capture_pkg::NUM_CH-1:0][31:0] enc_values
);

    regmap_pkg::reg_cmd_t           cmd;
    capture_pkg::capture_cfg_t      cfg;
    capture_pkg::signal_spec_t      spec;
    capture_pkg::ram_wr_t           ram_wr;
    capture_pkg::buf_status_t       status;
    logic [3:0]                     spec_idx;
    logic [31:0]                    sel_data;
    logic [capture_pkg::RAM_AW-1:0] ram_raddr;
    logic [31:0]                    ram_rdata;

    wb_reg_decode wb_reg_decode_inst (
        .clkbuffer (clkbuffer),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .cmd       (cmd),
        .ram_raddr (ram_raddr),
        .ram_rdata (ram_rdata),
        .status    (status)
    );

    capture_config capture_config_inst (
        .clkbuffer (clkbuffer),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .busy      (status.busy),
        .spec_idx  (spec_idx),
        .spec      (spec),
        .cfg       (cfg)
    );

    sensor_select sensor_select_inst (
        .spec       (spec),
        .pot_values (pot_values),
        .cur_values (cur_values),
        .enc_values (enc_values),
        .sel_data   (sel_data)
    );

    capture_fsm capture_fsm_inst (
        .clkbuffer     (clkbuffer),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .cfg           (cfg),
        .sample_strobe (sample_strobe),
        .ts            (ts),
        .sel_data      (sel_data),
        .spec_idx      (spec_idx),
        .ram_wr        (ram_wr),
        .status        (status)
    );

    sample_ram sample_ram_inst (
        .clkbuffer (clkbuffer),
        .ram_wr    (ram_wr),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

endmodule

`default_nettype wire

// File: sample_ram.sv
// 32x1024 simple dual-port sample RAM
// one write port from capture, one registered read port for the host
`timescale 1ns/1ps
`default_nettype none

module sample_ram (
    input  logic                            clkbuffer,
    input  capture_pkg::ram_wr_t            ram_wr,
    input  logic [capture_pkg::RAM_AW-1:0]  raddr,
    output logic [31:0]                     rdata
);

    logic [31:0] mem [capture_pkg::RAM_DEPTH];

    always_ff @(posedge clkbuffer) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
        rdata <= mem[raddr];    // one cycle read latency
    end

endmodule

`default_nettype wire

// File: capture_fsm.sv
// collection state machine for the data collection buffer
// synchronizes the sample strobe, writes one timestamp word then one
// word per configured signal on each strobe edge
// sample mode ends after the frame target, continuous mode on stop
`timescale 1ns/1ps
`default_nettype none

module capture_fsm (
    input  logic                        clkbuffer,
    input  logic                        rst_n,
    input  regmap_pkg::reg_cmd_t        cmd,
    input  capture_pkg::capture_cfg_t   cfg,
    input  logic                        sample_strobe,
    input  logic [31:0]                 ts,
    input  logic [31:0]                 sel_data,
    output logic [3:0]                  spec_idx,
    output capture_pkg::ram_wr_t        ram_wr,
    output capture_pkg::buf_status_t    status
);

    logic                           strb_s1;
    logic                           strb_s2;
    logic                           strb_q;
    logic                           strb_edge;
    logic                           run;          // set by start, cleared by stop
    logic                           busy;
    logic [capture_pkg::RAM_AW-1:0] waddr;        // next write address
    logic [capture_pkg::RAM_AW-1:0] waddr_align;
    logic [10:0]                    frame_cnt;
    logic [3:0]                     idx;
    logic [31:0]                    stamp;
    logic                           frames_done;
    capture_pkg::cap_state_e        state;

    // strobe sync and edge detect --------------------
    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            strb_s1 <= 1'b0;
            strb_s2 <= 1'b0;
            strb_q  <= 1'b0;
        end else begin
            strb_s1 <= sample_strobe;
            strb_s2 <= strb_s1;
            strb_q  <= strb_s2;
        end
    end
    assign strb_edge = strb_s2 && !strb_q;   // acted on 3 edges after the strobe rises

    // timestamp word with over-14-bit flag
    assign stamp = {16'd0, 1'b1, (ts[31:14] != 18'd0), ts[13:0]};

    assign frames_done = (cfg.mode == capture_pkg::mode_sample) &&
                         (frame_cnt == cfg.samples);

    // collection FSM --------------------
    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            state       <= capture_pkg::st_idle;
            run         <= 1'b0;
            busy        <= 1'b0;
            ram_wr.en   <= 1'b0;
            waddr       <= '0;
            waddr_align <= '0;
            frame_cnt   <= 11'd0;
            idx         <= 4'd0;
        end else begin
            ram_wr.en <= 1'b0;                                  // write strobe by default off
            if (cmd.op == regmap_pkg::op_stop) run <= 1'b0;     // honoured between frames
            case (state)
                capture_pkg::st_idle: begin
                    if (cmd.op == regmap_pkg::op_start && cfg.ready) begin
                        run         <= 1'b1;
                        busy        <= 1'b1;
                        waddr       <= '0;       // first frame at address 0
                        waddr_align <= '0;
                        frame_cnt   <= 11'd0;
                        state       <= capture_pkg::st_wait_edge;
                    end
                end
                capture_pkg::st_wait_edge: begin
                    if (!run || frames_done) begin
                        busy  <= 1'b0;
                        state <= capture_pkg::st_idle;
                    end else if (strb_edge) begin
                        state <= capture_pkg::st_stamp;
                    end
                end
                capture_pkg::st_stamp: begin
                    ram_wr.en   <= 1'b1;
                    ram_wr.addr <= waddr;
                    ram_wr.data <= stamp;
                    waddr       <= waddr + 1'b1;   // wraps mod RAM depth
                    frame_cnt   <= frame_cnt + 11'd1;
                    idx         <= 4'd0;
                    state       <= capture_pkg::st_data;
                end
                capture_pkg::st_data: begin
                    if (idx != cfg.num) begin
                        ram_wr.en   <= 1'b1;
                        ram_wr.addr <= waddr;
                        ram_wr.data <= sel_data;    // spec[idx] reading
                        waddr       <= waddr + 1'b1;
                        idx         <= idx + 4'd1;
                    end else begin
                        waddr_align <= waddr;       // frame boundary for the host
                        state       <= capture_pkg::st_wait_edge;
                    end
                end
                default: state <= capture_pkg::st_idle;
            endcase
        end
    end

    assign spec_idx = idx;
    assign status   = '{busy: busy, num: cfg.num, waddr_align: waddr_align};

endmodule

`default_nettype wire

// File: sensor_select.sv
// sensor selector, picks the reading named by a signal spec
// four channels per source, result masked to the stored width
`timescale 1ns/1ps
`default_nettype none

module sensor_select (
    input  capture_pkg::signal_spec_t                        spec,
    input  logic [capture_pkg::NUM_CH-1:0][15:0]             pot_values,
    input  logic [capture_pkg::NUM_CH-1:0][15:0]             cur_values,
    input  logic [capture_pkg::NUM_CH-1:0][31:0]             enc_values,
    output logic [31:0]                                      sel_data
);

    logic                        ch_ok;     // channel exists on every source
    logic [capture_pkg::CH_W-1:0] ch;
    logic [31:0]                 raw;
    logic [31:0]                 mask;

    assign ch_ok = (spec.channel < capture_pkg::NUM_CH);
    assign ch    = spec.channel[capture_pkg::CH_W-1:0];

    always_comb begin
        raw = 32'd0;
        if (ch_ok) begin
            case (spec.dtype)
                capture_pkg::src_pot: raw = {16'd0, pot_values[ch]};
                capture_pkg::src_cur: raw = {16'd0, cur_values[ch]};
                capture_pkg::src_enc: raw = enc_values[ch];
                default:              raw = 32'd0;   // unknown source
            endcase
        end
    end

    always_comb begin
        case (spec.fmt)
            capture_pkg::fmt_8:  mask = 32'h0000_00ff;
            capture_pkg::fmt_16: mask = 32'h0000_ffff;
            capture_pkg::fmt_24: mask = 32'h00ff_ffff;
            default:             mask = 32'hffff_ffff;   // fmt_32 and unused codes
        endcase
    end

    assign sel_data = raw & mask;   // zero-filled above the format

endmodule

`default_nettype wire

// File: capture_config.sv
// frame layout and collection mode registers
// holds signal count, spec table, mode and frame target
// all host updates are dropped while collection is busy
`timescale 1ns/1ps
`default_nettype none

module capture_config (
    input  logic                        clkbuffer,
    input  logic                        rst_n,
    input  regmap_pkg::reg_cmd_t        cmd,
    input  logic                        busy,
    input  logic [3:0]                  spec_idx,
    output capture_pkg::signal_spec_t   spec,
    output capture_pkg::capture_cfg_t   cfg
);

    logic [3:0]                 num;
    logic [4:0]                 ptr;        // specs written since count write
    capture_pkg::mode_e         mode;
    logic [10:0]                samples;
    logic                       spec_wr;
    capture_pkg::signal_spec_t  spec_tab [capture_pkg::MAX_SIGNALS];

    assign spec_wr = !busy && (cmd.op == regmap_pkg::op_spec) &&
                     (ptr < capture_pkg::MAX_SIGNALS);    // table full, extra specs dropped

    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            num     <= 4'd0;
            ptr     <= 5'd0;
            mode    <= capture_pkg::mode_sample;
            samples <= 11'd0;
        end else if (!busy) begin
            case (cmd.op)
                regmap_pkg::op_num: begin
                    num <= cmd.wdata[3:0];
                    ptr <= 5'd0;           // new layout starts over
                end
                regmap_pkg::op_mode_sample: begin
                    mode    <= capture_pkg::mode_sample;
                    samples <= cmd.wdata[10:0];
                end
                regmap_pkg::op_mode_cont: begin
                    mode    <= capture_pkg::mode_continuous;
                    samples <= 11'd0;
                end
                default: begin
                    if (spec_wr) ptr <= ptr + 5'd1;
                end
            endcase
        end
    end

    // spec table, host wdata bits 15:12 / 7:4 / 3:0
    always_ff @(posedge clkbuffer) begin
        if (spec_wr) begin
            spec_tab[ptr[3:0]] <= '{dtype:   capture_pkg::src_type_e'(cmd.wdata[15:12]),
                                    channel: cmd.wdata[7:4],
                                    fmt:     capture_pkg::fmt_e'(cmd.wdata[3:0])};
        end
    end

    assign spec = spec_tab[spec_idx];     // looked up by the FSM each data cycle
    assign cfg  = '{num:     num,
                    mode:    mode,
                    samples: samples,
                    ready:   (num != 4'd0) && (ptr == {1'b0, num})};

endmodule

`default_nettype wire

// File: wb_reg_decode.sv
// wishbone classic slave for the data collection buffer
// turns host writes into one-cycle register ops, returns RAM or status data
// ack comes one cycle after the request and never two cycles in a row
`timescale 1ns/1ps
`default_nettype none

module wb_reg_decode (
    input  logic                            clkbuffer,
    input  logic                            rst_n,
    input  regmap_pkg::wb_req_t             wb_req,
    output regmap_pkg::wb_rsp_t             wb_rsp,
    output regmap_pkg::reg_cmd_t            cmd,
    output logic [capture_pkg::RAM_AW-1:0]  ram_raddr,
    input  logic [31:0]                     ram_rdata,
    input  capture_pkg::buf_status_t        status
);

    logic                           ack;
    logic                           req;          // new access this cycle
    logic                           ram_hit;      // address inside RAM window
    logic                           rd_ram;       // registered read select
    logic [31:0]                    rd_word;      // registered non-RAM read data
    logic [capture_pkg::RAM_AW-1:0] last_raddr;
    regmap_pkg::reg_op_e            op_dec;
    regmap_pkg::reg_op_e            cmd_op;
    logic [31:0]                    cmd_wdata;

    assign req     = wb_req.cyc && wb_req.stb && !ack;    // blocked in the ack cycle
    assign ram_hit = (wb_req.adr[regmap_pkg::ADDR_W-1:capture_pkg::RAM_AW] ==
                      regmap_pkg::RAM_BASE[regmap_pkg::ADDR_W-1:capture_pkg::RAM_AW]);

    assign ram_raddr = wb_req.adr[capture_pkg::RAM_AW-1:0];   // RAM sees it in request cycle

    // write address decode --------------------
    always_comb begin
        case (wb_req.adr)
            regmap_pkg::REG_NUM:         op_dec = regmap_pkg::op_num;
            regmap_pkg::REG_SPEC:        op_dec = regmap_pkg::op_spec;
            regmap_pkg::REG_MODE_SAMPLE: op_dec = regmap_pkg::op_mode_sample;
            regmap_pkg::REG_MODE_CONT:   op_dec = regmap_pkg::op_mode_cont;
            regmap_pkg::REG_START:       op_dec = regmap_pkg::op_start;
            regmap_pkg::REG_STOP:        op_dec = regmap_pkg::op_stop;
            default:                     op_dec = regmap_pkg::op_none;   // RAM, status, holes
        endcase
    end

    // handshake and control --------------------
    always_ff @(posedge clkbuffer) begin
        if (!rst_n) begin
            ack        <= 1'b0;
            cmd_op     <= regmap_pkg::op_none;
            last_raddr <= '0;
        end else begin
            ack    <= req;
            cmd_op <= (req && wb_req.we) ? op_dec : regmap_pkg::op_none;  // same edge as ack
            if (req && !wb_req.we && ram_hit) begin
                last_raddr <= wb_req.adr[capture_pkg::RAM_AW-1:0];   // host read pointer
            end
        end
    end

    // read data and write payload, captured with the request
    always_ff @(posedge clkbuffer) begin
        if (req) begin
            cmd_wdata <= wb_req.dat;
            rd_ram    <= ram_hit;
            if (wb_req.adr == regmap_pkg::REG_STATUS) begin
                rd_word <= {6'd0, last_raddr, status.busy, 1'b0, status.num,
                            status.waddr_align};
            end else begin
                rd_word <= 32'd0;     // unmapped reads give zero
            end
        end
    end

    assign cmd = '{op: cmd_op, wdata: cmd_wdata};
    assign wb_rsp = '{ack: ack, dat: (rd_ram ? ram_rdata : rd_word)};

endmodule

`default_nettype wire

// File: capture_pkg.sv
// capture side types for the data collection buffer
// frame layout, collection mode, RAM write port and status
`default_nettype none

package capture_pkg;

    localparam int RAM_AW      = 10;
    localparam int RAM_DEPTH   = 1024;
    localparam int MAX_SIGNALS = 16;          // spec table entries
    localparam int NUM_CH      = 4;           // channels per source
    localparam int CH_W        = $clog2(NUM_CH);

    typedef enum logic [3:0] {
        src_pot = 4'd0,
        src_cur = 4'd1,
        src_enc = 4'd2
    } src_type_e;    // other codes read as zero

    typedef enum logic [3:0] {
        fmt_8  = 4'd0,
        fmt_16 = 4'd1,
        fmt_24 = 4'd2,
        fmt_32 = 4'd3
    } fmt_e;    // other codes store all 32 bits

    typedef enum logic {
        mode_sample,
        mode_continuous
    } mode_e;

    typedef struct packed {
        src_type_e  dtype;      // host wdata[15:12]
        logic [3:0] channel;    // host wdata[7:4]
        fmt_e       fmt;        // host wdata[3:0]
    } signal_spec_t;

    typedef struct packed {
        logic [3:0]  num;
        mode_e       mode;
        logic [10:0] samples;
        logic        ready;    // layout complete
    } capture_cfg_t;

    typedef struct packed {
        logic              en;
        logic [RAM_AW-1:0] addr;
        logic [31:0]       data;
    } ram_wr_t;

    typedef struct packed {
        logic              busy;
        logic [3:0]        num;
        logic [RAM_AW-1:0] waddr_align;
    } buf_status_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_edge,
        st_stamp,
        st_data
    } cap_state_e;

endpackage

`default_nettype wire

// File: regmap_pkg.sv
// host register map for the data collection buffer
// wishbone classic request and response bundles, decoded register writes
`default_nettype none

package regmap_pkg;

    localparam int ADDR_W = 12;    // host word address width

    // address map --------
    localparam logic [ADDR_W-1:0] RAM_BASE        = 12'h000;  // 0x000-0x3ff, read only
    localparam logic [ADDR_W-1:0] REG_STATUS      = 12'h800;  // read only
    localparam logic [ADDR_W-1:0] REG_NUM         = 12'h900;  // signal count
    localparam logic [ADDR_W-1:0] REG_SPEC        = 12'h901;  // append one spec
    localparam logic [ADDR_W-1:0] REG_MODE_SAMPLE = 12'h902;  // sample mode + frame count
    localparam logic [ADDR_W-1:0] REG_MODE_CONT   = 12'h903;  // continuous mode
    localparam logic [ADDR_W-1:0] REG_START       = 12'h904;
    localparam logic [ADDR_W-1:0] REG_STOP        = 12'h905;

    // bus bundles --------
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [31:0]       dat;
    } wb_req_t;    // 47 bits

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        op_none,
        op_num,
        op_spec,
        op_mode_sample,
        op_mode_cont,
        op_start,
        op_stop
    } reg_op_e;

    // one decoded host write, valid for a single cycle
    typedef struct packed {
        reg_op_e     op;
        logic [31:0] wdata;
    } reg_cmd_t;

endpackage

`default_nettype wire
